/* Makefile */
# Verilator build and run of the core testbench.

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -f src.f
	./obj_dir/Vcore_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/committer.sv */
// Result stage; presents commit records in order and retires them into the register file.
module committer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  exe_valid,
  output logic                  exe_ready,
  input  pipe_pkg::commit_pkt_t exe_data,
  output logic                  commit_valid,
  input  logic                  commit_ready,
  output pipe_pkg::commit_pkt_t commit_data,
  output pipe_pkg::wb_t         wb
);

  logic commit_fire;

  assign exe_ready = !commit_valid || commit_ready;
  assign commit_fire = commit_valid && commit_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_valid <= 1'b0;
    end else if (exe_ready) begin
      commit_valid <= exe_valid;
    end
  end

  // Held unchanged while the sink stalls.
  always_ff @(posedge clk) begin
    if (exe_valid && exe_ready) begin
      commit_data <= exe_data;
    end
  end

  // The write also frees the scoreboard entry.
  always_comb begin
    wb.en = commit_fire && commit_data.writes_rd && (commit_data.rd != '0);
    wb.rd = commit_data.rd;
    wb.value = commit_data.value;
  end

endmodule

/* design/core_settings.svh */
// Architectural widths of the integer back end, included by the packages and the register file.
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of a data word and of a pc.
`define XLEN 32

// Integer registers, x0 included.
`define NUM_REGS 32

// Bits needed to name one register.
`define REG_ADDR_W 5

`endif

/* design/core_top.sv */
// Top level of the integer back end; chains decode, issue, execute and commit.
module core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  pipe_pkg::fetch_pkt_t  in_data,
  output logic                  commit_valid,
  input  logic                  commit_ready,
  output pipe_pkg::commit_pkt_t commit_data
);

  logic                  dec_valid;
  logic                  dec_ready;
  pipe_pkg::dec_pkt_t    dec_data;
  logic                  iss_valid;
  logic                  iss_ready;
  pipe_pkg::issue_pkt_t  iss_data;
  logic                  exe_valid;
  logic                  exe_ready;
  pipe_pkg::commit_pkt_t exe_data;
  pipe_pkg::wb_t         wb;

  decoder decoder_inst (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data(in_data),
    .dec_valid(dec_valid),
    .dec_ready(dec_ready),
    .dec_data(dec_data)
  );

  regfile regfile_inst (
    .clk(clk),
    .rst(rst),
    .dec_valid(dec_valid),
    .dec_ready(dec_ready),
    .dec_data(dec_data),
    .iss_valid(iss_valid),
    .iss_ready(iss_ready),
    .iss_data(iss_data),
    .wb(wb)  // From commit.
  );

  int_exec int_exec_inst (
    .clk(clk),
    .rst(rst),
    .iss_valid(iss_valid),
    .iss_ready(iss_ready),
    .iss_data(iss_data),
    .exe_valid(exe_valid),
    .exe_ready(exe_ready),
    .exe_data(exe_data)
  );

  committer committer_inst (
    .clk(clk),
    .rst(rst),
    .exe_valid(exe_valid),
    .exe_ready(exe_ready),
    .exe_data(exe_data),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .commit_data(commit_data),
    .wb(wb)
  );

endmodule

/* design/decoder.sv */
// Decode stage; turns each incoming fetch packet into a registered decode packet.
module decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  pipe_pkg::fetch_pkt_t in_data,
  output logic                 dec_valid,
  input  logic                 dec_ready,
  output pipe_pkg::dec_pkt_t   dec_data
);

  rv_isa_pkg::instr_t instr;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  rv_isa_pkg::xlen_t  imm_i;
  rv_isa_pkg::xlen_t  imm_u;
  rv_isa_pkg::xlen_t  imm_b;
  rv_isa_pkg::xlen_t  imm_j;
  logic               legal;
  logic               use_rs1;
  logic               use_rs2;
  pipe_pkg::dec_pkt_t dec;

  assign instr  = in_data.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_u  = {instr[31:12], 12'b0};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;  // ADD, no branch.
    dec.pc = in_data.pc;
    legal = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (instr[6:0])
      rv_isa_pkg::OPC_LUI: begin
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op = rv_isa_pkg::ALU_PASS_B;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc = 1'b1;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        dec.imm = imm_j;
        dec.link = 1'b1;
        dec.br_cond = rv_isa_pkg::BR_ALWAYS;
        dec.writes_rd = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        dec.imm = imm_i;
        dec.link = 1'b1;
        dec.jalr = 1'b1;
        dec.br_cond = rv_isa_pkg::BR_ALWAYS;
        dec.writes_rd = 1'b1;
        use_rs1 = 1'b1;
        legal = (funct3 == 3'b000);
      end
      rv_isa_pkg::OPC_BRANCH: begin
        dec.imm = imm_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000: dec.br_cond = rv_isa_pkg::BR_EQ;
          3'b001: dec.br_cond = rv_isa_pkg::BR_NE;
          3'b100: dec.br_cond = rv_isa_pkg::BR_LT;
          3'b101: dec.br_cond = rv_isa_pkg::BR_GE;
          3'b110: dec.br_cond = rv_isa_pkg::BR_LTU;
          3'b111: dec.br_cond = rv_isa_pkg::BR_GEU;
          default: legal = 1'b0;
        endcase
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
        use_rs1 = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = rv_isa_pkg::ALU_ADD;
          3'b010: dec.alu_op = rv_isa_pkg::ALU_SLT;
          3'b011: dec.alu_op = rv_isa_pkg::ALU_SLTU;
          3'b100: dec.alu_op = rv_isa_pkg::ALU_XOR;
          3'b110: dec.alu_op = rv_isa_pkg::ALU_OR;
          3'b111: dec.alu_op = rv_isa_pkg::ALU_AND;
          3'b001: begin
            dec.alu_op = rv_isa_pkg::ALU_SLL;
            legal = (funct7 == 7'b0000000);
          end
          default: begin  // Shift right, logical or arithmetic by funct7.
            dec.alu_op = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      rv_isa_pkg::OPC_OP: begin
        dec.writes_rd = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec.alu_op = rv_isa_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: dec.alu_op = rv_isa_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: dec.alu_op = rv_isa_pkg::ALU_SLL;
          {7'b0000000, 3'b010}: dec.alu_op = rv_isa_pkg::ALU_SLT;
          {7'b0000000, 3'b011}: dec.alu_op = rv_isa_pkg::ALU_SLTU;
          {7'b0000000, 3'b100}: dec.alu_op = rv_isa_pkg::ALU_XOR;
          {7'b0000000, 3'b101}: dec.alu_op = rv_isa_pkg::ALU_SRL;
          {7'b0100000, 3'b101}: dec.alu_op = rv_isa_pkg::ALU_SRA;
          {7'b0000000, 3'b110}: dec.alu_op = rv_isa_pkg::ALU_OR;
          {7'b0000000, 3'b111}: dec.alu_op = rv_isa_pkg::ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    dec.rs1 = use_rs1 ? instr[19:15] : '0;
    dec.rs2 = use_rs2 ? instr[24:20] : '0;
    dec.rd = dec.writes_rd ? instr[11:7] : '0;
    // Unknown words keep only the pc; value and registers stay zero.
    if (!legal) begin
      dec = '0;
      dec.pc = in_data.pc;
      dec.illegal = 1'b1;
    end
  end

  assign in_ready = !dec_valid || dec_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (in_ready) begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dec_data <= dec;
    end
  end

endmodule

/* design/int_exec.sv */
// Execute stage; ALU and branch/jump resolution producing a registered commit record.
module int_exec (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  iss_valid,
  output logic                  iss_ready,
  input  pipe_pkg::issue_pkt_t  iss_data,
  output logic                  exe_valid,
  input  logic                  exe_ready,
  output pipe_pkg::commit_pkt_t exe_data
);

  pipe_pkg::dec_pkt_t    dec;
  rv_isa_pkg::xlen_t     op_a;
  rv_isa_pkg::xlen_t     op_b;
  logic [4:0]            shamt;
  rv_isa_pkg::xlen_t     alu_res;
  rv_isa_pkg::xlen_t     pc_plus4;
  rv_isa_pkg::xlen_t     target;
  logic                  taken;
  pipe_pkg::commit_pkt_t res;

  assign dec = iss_data.dec;
  assign op_a = dec.use_pc ? dec.pc : iss_data.rs1_val;
  assign op_b = dec.use_imm ? dec.imm : iss_data.rs2_val;
  assign shamt = op_b[4:0];  // Upper bits of the amount are ignored.
  assign pc_plus4 = dec.pc + 32'd4;

  always_comb begin
    case (dec.alu_op)
      rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_isa_pkg::ALU_SLT:    alu_res = rv_isa_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      rv_isa_pkg::ALU_SLTU:   alu_res = rv_isa_pkg::xlen_t'(op_a < op_b);
      rv_isa_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_isa_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_isa_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
      default:                alu_res = op_a + op_b;
    endcase
  end

  // Conditions always look at the register operands.
  always_comb begin
    case (dec.br_cond)
      rv_isa_pkg::BR_EQ:     taken = iss_data.rs1_val == iss_data.rs2_val;
      rv_isa_pkg::BR_NE:     taken = iss_data.rs1_val != iss_data.rs2_val;
      rv_isa_pkg::BR_LT:     taken = $signed(iss_data.rs1_val) < $signed(iss_data.rs2_val);
      rv_isa_pkg::BR_GE:     taken = $signed(iss_data.rs1_val) >= $signed(iss_data.rs2_val);
      rv_isa_pkg::BR_LTU:    taken = iss_data.rs1_val < iss_data.rs2_val;
      rv_isa_pkg::BR_GEU:    taken = iss_data.rs1_val >= iss_data.rs2_val;
      rv_isa_pkg::BR_ALWAYS: taken = 1'b1;
      default:               taken = 1'b0;
    endcase
  end

  assign target = dec.jalr ? ((iss_data.rs1_val + dec.imm) & ~rv_isa_pkg::xlen_t'(1))
                           : (dec.pc + dec.imm);

  always_comb begin
    res.pc = dec.pc;
    res.rd = dec.rd;
    res.writes_rd = dec.writes_rd;
    res.illegal = dec.illegal;
    res.value = dec.writes_rd ? (dec.link ? pc_plus4 : alu_res) : '0;  // Zero if nothing written.
    res.next_pc = taken ? target : pc_plus4;
  end

  assign iss_ready = !exe_valid || exe_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
    end else if (iss_ready) begin
      exe_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid && iss_ready) begin
      exe_data <= res;
    end
  end

endmodule

/* design/pipe_pkg.sv */
// Packet formats passed between the pipeline stages; referenced by scoped name.
`include "core_settings.svh"

package pipe_pkg;

  // Input stream payload.
  typedef struct packed {
    rv_isa_pkg::xlen_t  pc;
    rv_isa_pkg::instr_t instr;
  } fetch_pkt_t;

  // Unused register fields are zero so they never hit the scoreboard.
  typedef struct packed {
    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::xlen_t     imm;
    rv_isa_pkg::alu_op_e   alu_op;
    rv_isa_pkg::br_cond_e  br_cond;
    logic                  use_imm;    // Operand b is the immediate.
    logic                  use_pc;     // Operand a is the pc.
    logic                  link;       // Result is pc+4.
    logic                  jalr;       // Target base is rs1.
    logic                  writes_rd;
    logic                  illegal;
  } dec_pkt_t;

  typedef struct packed {
    dec_pkt_t          dec;
    rv_isa_pkg::xlen_t rs1_val;
    rv_isa_pkg::xlen_t rs2_val;
  } issue_pkt_t;

  // One retired instruction, as seen on the output stream.
  typedef struct packed {
    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::xlen_t     value;
    logic                  writes_rd;
    rv_isa_pkg::xlen_t     next_pc;
    logic                  illegal;
  } commit_pkt_t;

  typedef struct packed {
    logic                  en;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::xlen_t     value;
  } wb_t;

endpackage

/* design/regfile.sv */
// Register file with busy-bit scoreboard; issues decoded instructions once their registers are free.
`include "core_settings.svh"

module regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dec_valid,
  output logic                 dec_ready,
  input  pipe_pkg::dec_pkt_t   dec_data,
  output logic                 iss_valid,
  input  logic                 iss_ready,
  output pipe_pkg::issue_pkt_t iss_data,
  input  pipe_pkg::wb_t        wb
);

  rv_isa_pkg::xlen_t    regs [1:`NUM_REGS-1];  // x0 is not stored.
  logic [`NUM_REGS-1:0] busy;                  // Bit 0 never sets.
  logic                 hazard;
  logic                 out_free;
  logic                 issue;
  rv_isa_pkg::xlen_t    rs1_val;
  rv_isa_pkg::xlen_t    rs2_val;

  // No bypass from write-back. A waiting instruction goes the cycle after the commit.
  assign hazard = busy[dec_data.rs1] || busy[dec_data.rs2] || busy[dec_data.rd];
  assign out_free = !iss_valid || iss_ready;
  assign dec_ready = out_free && !hazard;
  assign issue = dec_valid && dec_ready;

  assign rs1_val = (dec_data.rs1 == '0) ? '0 : regs[dec_data.rs1];
  assign rs2_val = (dec_data.rs2 == '0) ? '0 : regs[dec_data.rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
      busy <= '0;
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (out_free) begin
        iss_valid <= issue;
      end
      // Retire first. An issuing rd is never busy, so the two never collide.
      if (wb.en) begin
        regs[wb.rd] <= wb.value;
        busy[wb.rd] <= 1'b0;
      end
      if (issue && dec_data.writes_rd && (dec_data.rd != '0)) begin
        busy[dec_data.rd] <= 1'b1;  // Claim the destination.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      iss_data.dec <= dec_data;
      iss_data.rs1_val <= rs1_val;
      iss_data.rs2_val <= rs2_val;
    end
  end

endmodule

/* design/rv_isa_pkg.sv */
// Architectural RV32I types shared by every stage; referenced by scoped name.
`include "core_settings.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] xlen_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0] instr_t;  // Fixed at 32 bits for the base ISA.

  // Major opcodes of the supported instruction groups.
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // ALU_ADD must stay at zero. An all-zero decode packet relies on it.
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Condition under which next pc takes the target.
  typedef enum logic [2:0] {
    BR_NONE   = 3'd0,
    BR_EQ     = 3'd1,
    BR_NE     = 3'd2,
    BR_LT     = 3'd3,
    BR_GE     = 3'd4,
    BR_LTU    = 3'd5,
    BR_GEU    = 3'd6,
    BR_ALWAYS = 3'd7
  } br_cond_e;

endpackage

/* src.f */
+incdir+design
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/decoder.sv
design/regfile.sv
design/int_exec.sv
design/committer.sv
design/core_top.sv
tb/core_props.sv
tb/core_checker.sv
tb/core_tb.sv

/* tb/core_checker.sv */
// Commit checker for core_top; models the RV32I registers and compares each commit in input order.
`include "core_settings.svh"

module core_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic                  in_ready,
  input  pipe_pkg::fetch_pkt_t  in_data,
  input  logic                  commit_valid,
  input  logic                  commit_ready,
  input  pipe_pkg::commit_pkt_t commit_data,
  output int                    error_count,
  output int                    commit_count
);

  pipe_pkg::fetch_pkt_t  pending [$];
  rv_isa_pkg::xlen_t     model [`NUM_REGS];
  pipe_pkg::fetch_pkt_t  pkt;
  pipe_pkg::commit_pkt_t exp_pkt;

  // RV32I arithmetic by funct3; alt picks SUB or SRA.
  function automatic rv_isa_pkg::xlen_t alu_result(input logic [2:0] f3, input logic alt,
                                                   input rv_isa_pkg::xlen_t a,
                                                   input rv_isa_pkg::xlen_t b);
    case (f3)
      3'b000: begin
        if (alt) begin
          return a - b;
        end
        return a + b;
      end
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic pipe_pkg::commit_pkt_t expect_commit(input rv_isa_pkg::xlen_t regs [`NUM_REGS],
                                                          input pipe_pkg::fetch_pkt_t p);
    rv_isa_pkg::instr_t    w;
    logic [2:0]            f3;
    logic [6:0]            f7;
    rv_isa_pkg::xlen_t     a;
    rv_isa_pkg::xlen_t     b;
    rv_isa_pkg::xlen_t     imm_i;
    rv_isa_pkg::xlen_t     pc4;
    logic                  ok;
    logic                  taken;
    pipe_pkg::commit_pkt_t e;
    w = p.instr;
    f3 = w[14:12];
    f7 = w[31:25];
    a = regs[w[19:15]];
    b = regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    pc4 = p.pc + 32'd4;
    ok = 1'b1;
    taken = 1'b0;
    e = '0;
    e.pc = p.pc;
    e.next_pc = pc4;
    e.writes_rd = 1'b1;
    e.rd = w[11:7];
    case (w[6:0])
      7'b0110111: e.value = {w[31:12], 12'b0};  // LUI.
      7'b0010111: e.value = p.pc + {w[31:12], 12'b0};
      7'b1101111: begin
        e.value = pc4;
        e.next_pc = p.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        e.value = pc4;
        e.next_pc = (a + imm_i) & 32'hffff_fffe;
        ok = (f3 == 3'b000);
      end
      7'b1100011: begin
        e.writes_rd = 1'b0;
        e.rd = '0;
        case (f3)
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = ($signed(a) < $signed(b));
          3'b101: taken = ($signed(a) >= $signed(b));
          3'b110: taken = (a < b);
          3'b111: taken = (a >= b);
          default: ok = 1'b0;
        endcase
        if (taken) begin
          e.next_pc = p.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b0010011: begin
        if (f3 == 3'b001) begin
          ok = (f7 == 7'b0000000);
        end else if (f3 == 3'b101) begin
          ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
        end
        e.value = alu_result(f3, (f3 == 3'b101) && f7[5], a, imm_i);
      end
      7'b0110011: begin
        ok = (f7 == 7'b0000000) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
        e.value = alu_result(f3, f7[5], a, b);
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      e = '0;
      e.pc = p.pc;
      e.next_pc = pc4;
      e.illegal = 1'b1;
    end
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERROR at time %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pending.delete();
      for (int i = 0; i < `NUM_REGS; i++) begin
        model[i] = '0;
      end
    end else begin
      if (in_valid && in_ready) begin
        pending.push_back(in_data);
      end
      if (commit_valid && commit_ready) begin
        if (pending.size() == 0) begin
          $display("Commit at time %0t arrived with no instruction outstanding", $time);
          error_count++;
        end else begin
          pkt = pending.pop_front();
          exp_pkt = expect_commit(model, pkt);
          check_field("pc", exp_pkt.pc, commit_data.pc);
          check_field("rd", 32'(exp_pkt.rd), 32'(commit_data.rd));
          check_field("value", exp_pkt.value, commit_data.value);
          check_field("writes_rd", 32'(exp_pkt.writes_rd), 32'(commit_data.writes_rd));
          check_field("next_pc", exp_pkt.next_pc, commit_data.next_pc);
          check_field("illegal", 32'(exp_pkt.illegal), 32'(commit_data.illegal));
          if (exp_pkt.writes_rd && exp_pkt.rd != '0) begin
            model[exp_pkt.rd] = exp_pkt.value;  // x0 stays zero.
          end
          commit_count++;
        end
      end
    end
  end

endmodule

/* tb/core_props.sv */
// Concurrent checks on the commit stream and write-back of core_top; attached by bind below.
`include "core_settings.svh"

module core_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  commit_valid,
  input logic                  commit_ready,
  input pipe_pkg::commit_pkt_t commit_data,
  input pipe_pkg::wb_t         wb,
  input logic [`NUM_REGS-1:0]  busy
);

  int fail_count;  // Read by the testbench top.

  commit_hold: assert property (@(posedge clk) disable iff (rst)
    commit_valid && !commit_ready |=> $stable(commit_data))
    else begin
      fail_count++;
      $error("commit_data changed while the sink was stalled");
    end

  reset_idle: assert property (@(posedge clk) rst |=> !commit_valid)
    else begin
      fail_count++;
      $error("commit_valid high in the cycle after reset");
    end

  // A retiring write must release a register that issue claimed.
  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    wb.en |-> (wb.rd != '0) && busy[wb.rd])
    else begin
      fail_count++;
      $error("write-back targeted x0 or a register that was not busy");
    end

endmodule

bind core_top core_props i_props (
  .clk(clk),
  .rst(rst),
  .commit_valid(commit_valid),
  .commit_ready(commit_ready),
  .commit_data(commit_data),
  .wb(wb),
  .busy(regfile_inst.busy)
);

/* tb/core_tb.sv */
// Testbench top for core_top; drives a random RV32I stream with back-pressure and prints the verdict.
module core_tb;

  localparam int NUM_INSTR = 400;
  localparam int MAX_CYCLES = NUM_INSTR * 20;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  in_valid;
  logic                  in_ready;
  pipe_pkg::fetch_pkt_t  in_data;
  logic                  commit_valid;
  logic                  commit_ready;
  pipe_pkg::commit_pkt_t commit_data;
  int                    errors;
  int                    commits;
  int                    cycles;

  always #2 clk = ~clk;

  core_top i_dut (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data(in_data),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .commit_data(commit_data)
  );

  core_checker i_chk (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data(in_data),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .commit_data(commit_data),
    .error_count(errors),
    .commit_count(commits)
  );

  // Registers limited to x0..x7 so hazards come often.
  function automatic rv_isa_pkg::instr_t random_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  shamt;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  op;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    rd = 5'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    shamt = 5'($urandom);
    f3 = 3'($urandom);
    imm = 12'($urandom);
    boff = {12'($urandom), 1'b0};
    joff = {20'($urandom), 1'b0};
    case ($urandom_range(0, 9))
      0, 1, 2: begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0;
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
      end
      3, 4, 5: begin
        if (f3 == 3'b001) begin
          imm = {7'b0, shamt};
        end else if (f3 == 3'b101) begin
          imm = {($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0, shamt};  // SRAI or SRLI.
        end
        return {imm, rs1, f3, rd, 7'b0010011};
      end
      6: begin
        op = ($urandom_range(0, 1) == 0) ? 7'b0110111 : 7'b0010111;
        return {20'($urandom), rd, op};
      end
      7: begin
        if ($urandom_range(0, 1) == 0) begin
          return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
        end
        return {imm, rs1, 3'b000, rd, 7'b1100111};
      end
      8: return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      default: begin
        // Load opcode, or a multiply from the M extension.
        if ($urandom_range(0, 1) == 0) begin
          return {25'($urandom), 7'b0000011};
        end
        return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
      end
    endcase
  endfunction

  initial begin
    void'($urandom(32'h292b));
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    for (int n = 0; n < NUM_INSTR; n++) begin
      while ($urandom_range(0, 3) == 0) begin  // Idle gap.
        in_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      in_valid = 1'b1;
      in_data.pc = $urandom & 32'hffff_fffc;
      in_data.instr = random_instr();
      @(posedge clk);
      while (!in_ready) begin
        @(posedge clk);
      end
      #1;
    end
    in_valid = 1'b0;
  end

  // Sink alternates ready and stalled phases.
  initial begin
    commit_ready = 1'b0;
    @(posedge clk);
    forever begin
      #1 commit_ready = 1'b1;
      repeat ($urandom_range(1, 12)) @(posedge clk);
      #1 commit_ready = 1'b0;
      repeat ($urandom_range(1, 4)) @(posedge clk);
    end
  end

  initial begin
    cycles = 0;
    while (commits < NUM_INSTR && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    repeat (8) @(posedge clk);  // Catch late or duplicate commits.
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with only %0d commits seen", cycles, commits);
    end
    $display("Checker errors %0d, assertion failures %0d, commits %0d of %0d",
             errors, i_dut.i_props.fail_count, commits, NUM_INSTR);
    if (errors == 0 && i_dut.i_props.fail_count == 0 && commits == NUM_INSTR &&
        cycles < MAX_CYCLES) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
